/* logic/shb_macros.svh */
`ifndef SHB_MACROS_SVH
`define SHB_MACROS_SVH

// Bank registers per CPU
`define SHB_NBANK 8

// Control window, CPU address high byte
`define SHB_CTRL_PAGE 8'hE0

// Control offsets inside the window, 0 to 7 are the bank registers
`define SHB_OFS_SRST     4'd8
`define SHB_OFS_IRQ_ACK  4'd9
`define SHB_OFS_FIRQ_ACK 4'd10

// Bank 7 boots into the top of ROM
`define SHB_BANK_BOOT 9'h1FF

// Region codes, RAM in bits 21..19 and the rest in bits 21..16
`define SHB_RGN_RAM  3'b011
`define SHB_RGN_VRAM 6'h08
`define SHB_RGN_PAL  6'h09
`define SHB_RGN_OBJ  6'h0A
`define SHB_RGN_KEY  6'h0B
`define SHB_RGN_SND  6'h0C

`endif

/* logic/shb_pkg.sv */
`default_nettype none

package shb_pkg;

    // CPU side address
    typedef logic [15:0] cpu_addr_t;

    // Board address after banking
    typedef logic [21:0] bus_addr_t;

    typedef logic [7:0] byte_t;

    // Bank register, lands on board bits 21..13
    typedef logic [8:0] bank_t;

    // Bus owner, also the CPU index of the ack and pending vectors
    typedef enum logic {
        OWN_MASTER = 1'b0,
        OWN_SUB    = 1'b1
    } owner_e;

endpackage

`default_nettype wire

/* logic/shb_bus_if.sv */
`default_nettype none

// One CPU's bus pins
interface shb_cpu_if;
    shb_pkg::cpu_addr_t addr;
    shb_pkg::byte_t     dout;   // CPU write data
    logic               rnw;
    logic               vma;    // Valid memory address for the next cycle
    shb_pkg::byte_t     din;    // Held read data
    logic               irq_n;
    logic               firq_n;

    modport slot (
        input  addr, dout, rnw, vma,
        output din
    );

    modport intr (
        output irq_n, firq_n
    );
endinterface

// Access of whichever CPU holds the bus
interface shb_owner_if;
    shb_pkg::owner_e    owner;
    shb_pkg::cpu_addr_t addr;
    shb_pkg::byte_t     dout;
    logic               rnw;
    logic               vma;    // Registered at the start of the slot

    modport slot (
        output owner, addr, dout, rnw, vma
    );

    modport map (
        input  owner, addr, dout, rnw, vma
    );
endinterface

`default_nettype wire

/* logic/shb_bus_slot.sv */
`default_nettype none

module shb_bus_slot (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic [1:0]     cpu_cen,
    input  wire shb_pkg::byte_t bdin,

    shb_cpu_if.slot             mcpu,
    shb_cpu_if.slot             scpu,
    shb_owner_if.slot           own
);

    shb_pkg::owner_e owner;
    logic            mvma_q;
    logic            svma_q;
    shb_pkg::byte_t  mdin_q;
    shb_pkg::byte_t  sdin_q;

    // Ownership flips on each clock-enable phase.
    // cen[0] hands the bus to the sub, cen[1] back to the master,
    // and the incoming owner's vma is captured on the same pulse.
    always_ff @(posedge clk) begin
        if (reset) begin
            owner  <= shb_pkg::OWN_MASTER;
            mvma_q <= 1'b0;
            svma_q <= 1'b0;
        end else begin
            if (cpu_cen[0]) begin
                owner  <= shb_pkg::OWN_SUB;
                svma_q <= scpu.vma;
            end
            if (cpu_cen[1]) begin // Master wins a double pulse
                owner  <= shb_pkg::OWN_MASTER;
                mvma_q <= mcpu.vma;
            end
        end
    end

    // Read data reloads on every clock of the owner's slot
    always_ff @(posedge clk) begin
        if (owner == shb_pkg::OWN_SUB) begin
            sdin_q <= bdin;
        end else begin
            mdin_q <= bdin;
        end
    end

    assign mcpu.din = mdin_q;   // Holds through the sub's slot
    assign scpu.din = sdin_q;

    // Owner multiplexer
    always_comb begin
        own.owner = owner;
        if (owner == shb_pkg::OWN_SUB) begin
            own.addr = scpu.addr;
            own.dout = scpu.dout;
            own.rnw  = scpu.rnw;
            own.vma  = svma_q;
        end else begin
            own.addr = mcpu.addr;
            own.dout = mcpu.dout;
            own.rnw  = mcpu.rnw;
            own.vma  = mvma_q;
        end
    end

endmodule

`default_nettype wire

/* logic/shb_bank_mapper.sv */
`default_nettype none

`include "shb_macros.svh"

module shb_bank_mapper (
    input  wire logic              clk,
    input  wire logic              reset,

    shb_owner_if.map               own,

    input  wire logic [15:0]       obus_dout,
    input  wire shb_pkg::byte_t    mrom_data,
    input  wire shb_pkg::byte_t    srom_data,
    input  wire shb_pkg::byte_t    ram_dout,
    input  wire shb_pkg::byte_t    key_dout,
    input  wire shb_pkg::byte_t    vram_dout,
    input  wire shb_pkg::byte_t    pal_dout,
    input  wire logic              mrom_ok,
    input  wire logic              srom_ok,
    input  wire logic              ram_ok,

    output shb_pkg::bus_addr_t     baddr,
    output shb_pkg::byte_t         bdout,
    output logic                   brnw,
    output shb_pkg::byte_t         bdin,
    output logic                   mrom_cs,
    output logic                   srom_cs,
    output logic                   ram_cs,
    output logic                   key_cs,
    output logic                   vram_cs,
    output logic                   pal_cs,
    output logic                   sound_cs,
    output logic [1:0]             obus_we,
    output logic [10:0]            obus_addr,
    output logic                   bus_busy,
    output logic                   srst_n,
    output logic [1:0]             ack_irq,
    output logic [1:0]             ack_firq
);

    shb_pkg::bank_t mbank [`SHB_NBANK];
    shb_pkg::bank_t sbank [`SHB_NBANK];
    shb_pkg::bank_t cur_bank;
    shb_pkg::bank_t bank_new;
    logic [3:0]     ofs;
    logic           in_win;     // CPU address inside the control window
    logic           ctrl_we;
    logic           acc;        // Valid access outside the window
    logic           rom_hit;
    logic           obj_cs;
    logic           is_sub;

    assign is_sub   = own.owner == shb_pkg::OWN_SUB;
    assign in_win   = own.addr[15:8] == `SHB_CTRL_PAGE;
    assign ofs      = own.addr[3:0];
    assign ctrl_we  = in_win & own.vma & ~own.rnw;
    assign bank_new = {own.addr[4], own.dout}; // Address bit 4 is the ninth data bit

    // Register writes apply on the next clock, repeats rewrite the same value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `SHB_NBANK; i++) begin
                mbank[i] <= '0;
                sbank[i] <= '0;
            end
            mbank[`SHB_NBANK-1] <= `SHB_BANK_BOOT;
            sbank[`SHB_NBANK-1] <= `SHB_BANK_BOOT;
            srst_n <= 1'b0;  // Sub held until the master lets go
        end else if (ctrl_we) begin
            if (ofs < `SHB_OFS_SRST) begin
                if (is_sub) begin
                    sbank[ofs[2:0]] <= bank_new;
                end else begin
                    mbank[ofs[2:0]] <= bank_new;
                end
            end
            if (ofs == `SHB_OFS_SRST && !is_sub) begin
                srst_n <= own.dout[0];
            end
        end
    end

    // Acknowledge strobes go to the owning CPU only
    always_comb begin
        ack_irq  = 2'b00;
        ack_firq = 2'b00;
        if (ctrl_we && ofs == `SHB_OFS_IRQ_ACK) begin
            ack_irq[own.owner] = 1'b1;
        end
        if (ctrl_we && ofs == `SHB_OFS_FIRQ_ACK) begin
            ack_firq[own.owner] = 1'b1;
        end
    end

    // Bank lookup on the top three address bits
    assign cur_bank = is_sub ? sbank[own.addr[15:13]] : mbank[own.addr[15:13]];
    assign baddr    = {cur_bank, own.addr[12:0]};
    assign bdout    = own.dout;
    assign brnw     = own.rnw;

    // Region decode
    assign acc      = own.vma & ~in_win;
    assign rom_hit  = acc & baddr[21];
    assign mrom_cs  = rom_hit & ~is_sub;
    assign srom_cs  = rom_hit & is_sub;
    assign ram_cs   = acc && baddr[21:19] == `SHB_RGN_RAM;
    assign vram_cs  = acc && baddr[21:16] == `SHB_RGN_VRAM;
    assign pal_cs   = acc && baddr[21:16] == `SHB_RGN_PAL;
    assign obj_cs   = acc && baddr[21:16] == `SHB_RGN_OBJ;
    assign key_cs   = acc && baddr[21:16] == `SHB_RGN_KEY;
    assign sound_cs = acc && baddr[21:16] == `SHB_RGN_SND;

    // Object RAM is 16 bits wide, bit 11 picks the lane
    assign obus_we   = {2{obj_cs & ~own.rnw}} & {baddr[11], ~baddr[11]};
    assign obus_addr = baddr[10:0];

    // Read source priority
    always_comb begin
        if (mrom_cs) begin
            bdin = mrom_data;
        end else if (srom_cs) begin
            bdin = srom_data;
        end else if (ram_cs) begin
            bdin = ram_dout;
        end else if (key_cs) begin
            bdin = key_dout;
        end else if (vram_cs) begin
            bdin = vram_dout;
        end else if (pal_cs) begin
            bdin = pal_dout;
        end else if (obj_cs) begin
            bdin = baddr[11] ? obus_dout[15:8] : obus_dout[7:0];
        end else begin
            bdin = '0;  // Unmapped
        end
    end

    // Slow memories not ready yet
    assign bus_busy = (mrom_cs & ~mrom_ok) | (srom_cs & ~srom_ok) | (ram_cs & ~ram_ok);

endmodule

`default_nettype wire

/* logic/shb_irq_ctrl.sv */
`default_nettype none

module shb_irq_ctrl (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       lvbl,
    input  wire logic       firqn,
    input  wire logic [1:0] ack_irq,
    input  wire logic [1:0] ack_firq,

    shb_cpu_if.intr         mcpu,
    shb_cpu_if.intr         scpu
);

    logic       lvbl_q;
    logic       firqn_q;
    logic       vb_fall;
    logic       firq_fall;
    logic [1:0] irq_pend;   // Indexed by CPU
    logic [1:0] firq_pend;

    // Input samplers, follow the pins even in reset so no false edge
    always_ff @(posedge clk) begin
        lvbl_q  <= lvbl;
        firqn_q <= firqn;
    end

    assign vb_fall   = lvbl_q & ~lvbl;   // Start of vertical blank
    assign firq_fall = firqn_q & ~firqn;

    // An edge reaches both CPUs, each clears its own
    always_ff @(posedge clk) begin
        if (reset) begin
            irq_pend  <= 2'b00;
            firq_pend <= 2'b00;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (ack_irq[i]) begin
                    irq_pend[i] <= 1'b0;
                end else if (vb_fall) begin
                    irq_pend[i] <= 1'b1;
                end
                if (ack_firq[i]) begin
                    firq_pend[i] <= 1'b0;
                end else if (firq_fall) begin
                    firq_pend[i] <= 1'b1;
                end
            end
        end
    end

    assign mcpu.irq_n  = ~irq_pend[shb_pkg::OWN_MASTER];
    assign mcpu.firq_n = ~firq_pend[shb_pkg::OWN_MASTER];
    assign scpu.irq_n  = ~irq_pend[shb_pkg::OWN_SUB];
    assign scpu.firq_n = ~firq_pend[shb_pkg::OWN_SUB];

endmodule

`default_nettype wire

/* logic/shb_main.sv */
`default_nettype none

module shb_main (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic [1:0]         cpu_cen,  // 0 starts the sub slot, 1 the master slot
    input  wire logic               lvbl,
    input  wire logic               firqn,

    // Master CPU
    input  wire shb_pkg::cpu_addr_t m_addr,
    input  wire shb_pkg::byte_t     m_dout,
    input  wire logic               m_rnw,
    input  wire logic               m_vma,
    output shb_pkg::byte_t          m_din,
    output logic                    m_irq_n,
    output logic                    m_firq_n,

    // Sub CPU
    input  wire shb_pkg::cpu_addr_t s_addr,
    input  wire shb_pkg::byte_t     s_dout,
    input  wire logic               s_rnw,
    input  wire logic               s_vma,
    output shb_pkg::byte_t          s_din,
    output logic                    s_irq_n,
    output logic                    s_firq_n,

    // Memory side
    input  wire logic [15:0]        obus_dout,
    input  wire shb_pkg::byte_t     mrom_data,
    input  wire shb_pkg::byte_t     srom_data,
    input  wire shb_pkg::byte_t     ram_dout,
    input  wire shb_pkg::byte_t     key_dout,
    input  wire shb_pkg::byte_t     vram_dout,
    input  wire shb_pkg::byte_t     pal_dout,
    input  wire logic               mrom_ok,
    input  wire logic               srom_ok,
    input  wire logic               ram_ok,
    output shb_pkg::bus_addr_t      baddr,
    output shb_pkg::byte_t          bdout,
    output logic                    brnw,
    output logic                    mrom_cs,
    output logic                    srom_cs,
    output logic                    ram_cs,
    output logic                    key_cs,
    output logic                    vram_cs,
    output logic                    pal_cs,
    output logic                    sound_cs,
    output logic [1:0]              obus_we,
    output logic [10:0]             obus_addr,
    output logic                    bus_busy,
    output logic                    srst_n
);

    shb_pkg::byte_t bdin;
    logic [1:0]     ack_irq;
    logic [1:0]     ack_firq;

    shb_cpu_if   mcpu_if ();
    shb_cpu_if   scpu_if ();
    shb_owner_if own_if ();

    // CPU pins into the bus interfaces
    assign mcpu_if.addr = m_addr;
    assign mcpu_if.dout = m_dout;
    assign mcpu_if.rnw  = m_rnw;
    assign mcpu_if.vma  = m_vma;
    assign scpu_if.addr = s_addr;
    assign scpu_if.dout = s_dout;
    assign scpu_if.rnw  = s_rnw;
    assign scpu_if.vma  = s_vma;

    assign m_din    = mcpu_if.din;
    assign m_irq_n  = mcpu_if.irq_n;
    assign m_firq_n = mcpu_if.firq_n;
    assign s_din    = scpu_if.din;
    assign s_irq_n  = scpu_if.irq_n;
    assign s_firq_n = scpu_if.firq_n;

    shb_bus_slot u_slot (
        .clk     (clk),
        .reset   (reset),
        .cpu_cen (cpu_cen),
        .bdin    (bdin),
        .mcpu    (mcpu_if.slot),
        .scpu    (scpu_if.slot),
        .own     (own_if.slot)
    );

    shb_bank_mapper u_mapper (
        .clk       (clk),
        .reset     (reset),
        .own       (own_if.map),
        .obus_dout (obus_dout),
        .mrom_data (mrom_data),
        .srom_data (srom_data),
        .ram_dout  (ram_dout),
        .key_dout  (key_dout),
        .vram_dout (vram_dout),
        .pal_dout  (pal_dout),
        .mrom_ok   (mrom_ok),
        .srom_ok   (srom_ok),
        .ram_ok    (ram_ok),
        .baddr     (baddr),
        .bdout     (bdout),
        .brnw      (brnw),
        .bdin      (bdin),
        .mrom_cs   (mrom_cs),
        .srom_cs   (srom_cs),
        .ram_cs    (ram_cs),
        .key_cs    (key_cs),
        .vram_cs   (vram_cs),
        .pal_cs    (pal_cs),
        .sound_cs  (sound_cs),
        .obus_we   (obus_we),
        .obus_addr (obus_addr),
        .bus_busy  (bus_busy),
        .srst_n    (srst_n),
        .ack_irq   (ack_irq),
        .ack_firq  (ack_firq)
    );

    shb_irq_ctrl u_irq (
        .clk      (clk),
        .reset    (reset),
        .lvbl     (lvbl),
        .firqn    (firqn),
        .ack_irq  (ack_irq),
        .ack_firq (ack_firq),
        .mcpu     (mcpu_if.intr),
        .scpu     (scpu_if.intr)
    );

endmodule

`default_nettype wire

/* bench/shb_tb.sv */
`default_nettype none

`include "shb_macros.svh"

module shb_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_TRANS     = 3000;
    localparam int WATCHDOG_NS = N_TRANS * 6 * 10 + 2000;  // Six clocks per transaction at most

    logic        clk;
    logic        reset;
    logic [1:0]  cpu_cen;
    logic        lvbl;
    logic        firqn;
    logic [15:0] m_addr;
    logic [7:0]  m_dout;
    logic        m_rnw;
    logic        m_vma;
    logic [7:0]  m_din;
    logic        m_irq_n;
    logic        m_firq_n;
    logic [15:0] s_addr;
    logic [7:0]  s_dout;
    logic        s_rnw;
    logic        s_vma;
    logic [7:0]  s_din;
    logic        s_irq_n;
    logic        s_firq_n;
    logic [15:0] obus_dout;
    logic [7:0]  mrom_data;
    logic [7:0]  srom_data;
    logic [7:0]  ram_dout;
    logic [7:0]  key_dout;
    logic [7:0]  vram_dout;
    logic [7:0]  pal_dout;
    logic [2:0]  mem_ok;     // Master ROM, sub ROM, RAM
    logic [21:0] baddr;
    logic [7:0]  bdout;
    logic        brnw;
    logic        mrom_cs;
    logic        srom_cs;
    logic        ram_cs;
    logic        key_cs;
    logic        vram_cs;
    logic        pal_cs;
    logic        sound_cs;
    logic [1:0]  obus_we;
    logic [10:0] obus_addr;
    logic        bus_busy;
    logic        srst_n;

    integer      seed;
    int          errors = 0;
    int          checks = 0;

    // Model state indexed by CPU with the master at 0
    logic        owner_m;
    logic [1:0]  vma_m;
    logic [8:0]  bank_m [2][`SHB_NBANK];
    logic        srst_m;
    logic [1:0]  irq_m;
    logic [1:0]  firq_m;
    logic        lvbl_q_m;
    logic        firqn_q_m;
    logic [7:0]  din_m [2];
    logic [1:0]  din_known;
    logic [2:0]  cs_seen;    // Slow selects seen at the last falling edge
    logic [2:0]  cs_prev;
    int          wait_cnt [3];

    shb_main dut0 (
        .clk       (clk),
        .reset     (reset),
        .cpu_cen   (cpu_cen),
        .lvbl      (lvbl),
        .firqn     (firqn),
        .m_addr    (m_addr),
        .m_dout    (m_dout),
        .m_rnw     (m_rnw),
        .m_vma     (m_vma),
        .m_din     (m_din),
        .m_irq_n   (m_irq_n),
        .m_firq_n  (m_firq_n),
        .s_addr    (s_addr),
        .s_dout    (s_dout),
        .s_rnw     (s_rnw),
        .s_vma     (s_vma),
        .s_din     (s_din),
        .s_irq_n   (s_irq_n),
        .s_firq_n  (s_firq_n),
        .obus_dout (obus_dout),
        .mrom_data (mrom_data),
        .srom_data (srom_data),
        .ram_dout  (ram_dout),
        .key_dout  (key_dout),
        .vram_dout (vram_dout),
        .pal_dout  (pal_dout),
        .mrom_ok   (mem_ok[0]),
        .srom_ok   (mem_ok[1]),
        .ram_ok    (mem_ok[2]),
        .baddr     (baddr),
        .bdout     (bdout),
        .brnw      (brnw),
        .mrom_cs   (mrom_cs),
        .srom_cs   (srom_cs),
        .ram_cs    (ram_cs),
        .key_cs    (key_cs),
        .vram_cs   (vram_cs),
        .pal_cs    (pal_cs),
        .sound_cs  (sound_cs),
        .obus_we   (obus_we),
        .obus_addr (obus_addr),
        .bus_busy  (bus_busy),
        .srst_n    (srst_n)
    );

    // Memories answer from the board address
    // An idle ROM returns the inverted byte so the two ROM ports never match
    assign mrom_data = mrom_cs ? (baddr[7:0] ^ 8'hA5) : ~(baddr[7:0] ^ 8'hA5);
    assign srom_data = srom_cs ? (baddr[7:0] ^ 8'hA5) : ~(baddr[7:0] ^ 8'hA5);
    assign ram_dout  = baddr[7:0] ^ 8'h3C;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic reset_model();
        owner_m   = 1'b0;
        vma_m     = 2'b00;
        srst_m    = 1'b0;
        irq_m     = 2'b00;
        firq_m    = 2'b00;
        din_known = 2'b00;
        cs_seen   = 3'b000;
        lvbl_q_m  = lvbl;
        firqn_q_m = firqn;
        for (int c = 0; c < 2; c++) begin
            for (int b = 0; b < `SHB_NBANK; b++) begin
                bank_m[c][b] = (b == `SHB_NBANK - 1) ? `SHB_BANK_BOOT : 9'h000;
            end
        end
    endtask

    // Interrupt sources and slow memory ready lines
    task automatic drive_env();
        if (rand_below(16) == 0) lvbl <= ~lvbl;
        if (rand_below(24) == 0) firqn <= ~firqn;
        for (int i = 0; i < 3; i++) begin
            if (cs_seen[i] && !cs_prev[i]) begin
                wait_cnt[i] = rand_below(4);   // 0 to 3 clocks not ready
            end else if (wait_cnt[i] > 0) begin
                wait_cnt[i]--;
            end
            mem_ok[i] <= wait_cnt[i] == 0;
        end
        cs_prev = cs_seen;
    endtask

    task automatic tick();
        @(posedge clk);
        drive_env();
    endtask

    // One CPU cycle with a control write or a random access
    task automatic drive_cpu(input logic sub);
        logic [15:0] a;
        logic [7:0]  d;
        logic        rnw;
        logic        vma;
        d = 8'(rand_below(256));
        if (rand_below(4) == 0) begin
            a   = {`SHB_CTRL_PAGE, 3'b000, 1'(rand_below(2)), 4'(rand_below(11))};
            rnw = 1'b0;
            vma = 1'b1;
        end else begin
            a   = 16'(rand_below(65536));
            rnw = 1'(rand_below(2));
            vma = rand_below(4) != 0;
        end
        if (sub) begin
            s_addr <= a;
            s_dout <= d;
            s_rnw  <= rnw;
            s_vma  <= vma;
        end else begin
            m_addr <= a;
            m_dout <= d;
            m_rnw  <= rnw;
            m_vma  <= vma;
        end
    endtask

    // Checks and model step on the falling edge where all signals are settled
    always @(negedge clk) begin : model
        logic        sub;
        logic [15:0] a;
        logic [7:0]  d;
        logic        rnw;
        logic        vma;
        logic        ctrl;
        logic        acc;
        logic        obj;
        logic [21:0] ba;
        logic [6:0]  cs;
        logic [1:0]  we;
        logic [7:0]  rd;
        logic        busy;
        logic        vb_fall;
        logic        fq_fall;
        if (reset) begin
            reset_model();
        end else begin
            sub  = owner_m;
            a    = sub ? s_addr : m_addr;
            d    = sub ? s_dout : m_dout;
            rnw  = sub ? s_rnw : m_rnw;
            vma  = vma_m[sub];
            acc  = vma && a[15:8] != `SHB_CTRL_PAGE;
            ctrl = vma && a[15:8] == `SHB_CTRL_PAGE && !rnw;
            ba   = {bank_m[sub][a[15:13]], a[12:0]};
            cs[6] = acc && ba[21] && !sub;
            cs[5] = acc && ba[21] && sub;
            cs[4] = acc && ba[21:19] == `SHB_RGN_RAM;
            cs[3] = acc && ba[21:16] == `SHB_RGN_KEY;
            cs[2] = acc && ba[21:16] == `SHB_RGN_VRAM;
            cs[1] = acc && ba[21:16] == `SHB_RGN_PAL;
            cs[0] = acc && ba[21:16] == `SHB_RGN_SND;
            obj   = acc && ba[21:16] == `SHB_RGN_OBJ;
            we    = (obj && !rnw) ? (ba[11] ? 2'b10 : 2'b01) : 2'b00;
            if (cs[6] || cs[5]) rd = ba[7:0] ^ 8'hA5;
            else if (cs[4]) rd = ba[7:0] ^ 8'h3C;
            else if (cs[3]) rd = key_dout;
            else if (cs[2]) rd = vram_dout;
            else if (cs[1]) rd = pal_dout;
            else if (obj) rd = ba[11] ? obus_dout[15:8] : obus_dout[7:0];
            else rd = 8'h00;
            busy = (cs[6] && !mem_ok[0]) || (cs[5] && !mem_ok[1]) || (cs[4] && !mem_ok[2]);

            expect_eq("baddr", 32'(baddr), 32'(ba));
            expect_eq("bdout", 32'(bdout), 32'(d));
            expect_eq("brnw", 32'(brnw), 32'(rnw));
            expect_eq("mrom_cs", 32'(mrom_cs), 32'(cs[6]));
            expect_eq("srom_cs", 32'(srom_cs), 32'(cs[5]));
            expect_eq("ram_cs", 32'(ram_cs), 32'(cs[4]));
            expect_eq("key_cs", 32'(key_cs), 32'(cs[3]));
            expect_eq("vram_cs", 32'(vram_cs), 32'(cs[2]));
            expect_eq("pal_cs", 32'(pal_cs), 32'(cs[1]));
            expect_eq("sound_cs", 32'(sound_cs), 32'(cs[0]));
            expect_eq("obus_we", 32'(obus_we), 32'(we));
            expect_eq("obus_addr", 32'(obus_addr), 32'(ba[10:0]));
            expect_eq("bus_busy", 32'(bus_busy), 32'(busy));
            expect_eq("srst_n", 32'(srst_n), 32'(srst_m));
            expect_eq("m_irq_n", 32'(m_irq_n), 32'(!irq_m[0]));
            expect_eq("s_irq_n", 32'(s_irq_n), 32'(!irq_m[1]));
            expect_eq("m_firq_n", 32'(m_firq_n), 32'(!firq_m[0]));
            expect_eq("s_firq_n", 32'(s_firq_n), 32'(!firq_m[1]));
            if (din_known[0]) expect_eq("m_din", 32'(m_din), 32'(din_m[0]));
            if (din_known[1]) expect_eq("s_din", 32'(s_din), 32'(din_m[1]));

            // State for the next rising edge
            vb_fall = lvbl_q_m && !lvbl;
            fq_fall = firqn_q_m && !firqn;
            lvbl_q_m  = lvbl;
            firqn_q_m = firqn;
            if (ctrl && a[3:0] < `SHB_OFS_SRST) bank_m[sub][a[2:0]] = {a[4], d};
            if (ctrl && a[3:0] == `SHB_OFS_SRST && !sub) srst_m = d[0];  // Master only
            for (int i = 0; i < 2; i++) begin
                if (ctrl && a[3:0] == `SHB_OFS_IRQ_ACK && int'(sub) == i) irq_m[i] = 1'b0;
                else if (vb_fall) irq_m[i] = 1'b1;
                if (ctrl && a[3:0] == `SHB_OFS_FIRQ_ACK && int'(sub) == i) firq_m[i] = 1'b0;
                else if (fq_fall) firq_m[i] = 1'b1;
            end
            din_m[sub]     = rd;
            din_known[sub] = 1'b1;
            if (cpu_cen[0]) begin
                owner_m  = 1'b1;
                vma_m[1] = s_vma;
            end
            if (cpu_cen[1]) begin
                owner_m  = 1'b0;
                vma_m[0] = m_vma;
            end
            cs_seen = {cs[4], cs[5], cs[6]};
        end
    end

    initial begin
        int gap;
        seed = 62;
        reset     <= 1'b1;
        cpu_cen   <= 2'b00;
        lvbl      <= 1'b1;
        firqn     <= 1'b1;
        m_addr    <= 16'h0000;
        m_dout    <= 8'h00;
        m_rnw     <= 1'b1;
        m_vma     <= 1'b0;
        s_addr    <= 16'h0000;
        s_dout    <= 8'h00;
        s_rnw     <= 1'b1;
        s_vma     <= 1'b0;
        mem_ok    <= 3'b111;
        key_dout  <= 8'(rand_below(256));
        vram_dout <= 8'(rand_below(256));
        pal_dout  <= 8'(rand_below(256));
        obus_dout <= 16'(rand_below(65536));
        cs_prev = 3'b000;
        for (int i = 0; i < 3; i++) begin
            wait_cnt[i] = 0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // Sub and master slots alternate with the sub first
        for (int n = 0; n < N_TRANS; n++) begin
            tick();
            cpu_cen <= (n % 2 == 0) ? 2'b01 : 2'b10;
            drive_cpu(n % 2 == 0);
            tick();
            cpu_cen <= 2'b00;
            gap = 2 + rand_below(4);
            repeat (gap - 1) tick();
        end
        repeat (4) tick();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the transactions did not complete in the expected time");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+logic
logic/shb_pkg.sv
logic/shb_bus_if.sv
logic/shb_bus_slot.sv
logic/shb_bank_mapper.sv
logic/shb_irq_ctrl.sv
logic/shb_main.sv
bench/shb_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := shb_tb
FILELIST  := tb.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES) logic/shb_macros.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
